//--- hw/pitaya_pkg.sv
package pitaya_pkg;

  // ----------------------------------------
  // widths and address map
  // ----------------------------------------
  localparam int SAMPLE_W    = 14;                     // adc/dac sample
  localparam int BUS_W       = 32;                     // bus data and address
  localparam int REGION_LSB  = 20;                     // region index starts here
  localparam int REGION_BITS = 10;

  localparam logic [REGION_BITS-1:0] SYSCONF_REGION = 10'h3ff;  // top region
  localparam logic [BUS_W-1:0]       SYSCONF_ID     = 32'hfff00002;  // class + version
  localparam logic [REGION_LSB-1:0]  IRQ_CFG_BASE   = 20'hf0100;  // one word per region

  // ----------------------------------------
  // configuration word, two views
  // ----------------------------------------
  typedef struct packed {
    logic [11:0] rsvd;     // always zero
    logic [0:3]  line_en;  // enable, line 0 sits in the msb
    logic [3:0]  num0;     // irq number of line 0
    logic [3:0]  num1;
    logic [3:0]  num2;
    logic [3:0]  num3;
  } irq_cfg_t;

  typedef union packed {
    logic [BUS_W-1:0] raw;      // word as seen on the bus
    irq_cfg_t         irq_cfg;  // per-region interrupt setup
  } sysconf_word_t;

  // clamp to the signed sample range
  function automatic logic signed [SAMPLE_W-1:0] sat_sample(
    input logic signed [BUS_W-1:0] val
  );
    if (val > BUS_W'(2 ** (SAMPLE_W - 1) - 1)) begin
      return {1'b0, {(SAMPLE_W - 1){1'b1}}};  // +8191
    end else if (val < -(BUS_W'(2 ** (SAMPLE_W - 1)))) begin
      return {1'b1, {(SAMPLE_W - 1){1'b0}}};  // -8192
    end
    return val[SAMPLE_W-1:0];
  endfunction

endpackage

//--- hw/sys_bus_decoder.sv
module sys_bus_decoder #(
  parameter int NUM_REGIONS = 8,
  parameter int FIRST_FREE  = 3
) (
  input  logic                                      adc_clk,
  input  logic                                      rst_n_i,
  input  logic [pitaya_pkg::BUS_W-1:0]              sys_addr_i,
  input  logic                                      sys_wen_i,
  input  logic                                      sys_ren_i,
  input  logic [NUM_REGIONS*pitaya_pkg::BUS_W-1:0]  reg_rdata_i,  // region r at word r
  input  logic [NUM_REGIONS-1:0]                    reg_ack_i,
  input  logic [NUM_REGIONS-1:0]                    reg_err_i,
  input  logic [pitaya_pkg::BUS_W-1:0]              cfg_rdata_i,
  input  logic                                      cfg_ack_i,
  output logic [NUM_REGIONS-1:0]                    reg_wen_o,    // one-hot
  output logic [NUM_REGIONS-1:0]                    reg_ren_o,
  output logic                                      cfg_wen_o,
  output logic                                      cfg_ren_o,
  output logic [pitaya_pkg::BUS_W-1:0]              sys_rdata_o,
  output logic                                      sys_ack_o,
  output logic                                      sys_err_o
);

  logic [pitaya_pkg::REGION_BITS-1:0] region;
  logic [NUM_REGIONS-1:0]             reg_cs;      // held address selects region
  logic [NUM_REGIONS-1:0]             free_mask;   // regions with no block behind
  logic [NUM_REGIONS-1:0]             free_ack_q;
  logic                               cfg_cs;
  logic                               unk_cs;
  logic                               unk_ack_q;   // ack + err for unmapped index
  logic                               strobe;

  assign region = sys_addr_i[pitaya_pkg::REGION_LSB +: pitaya_pkg::REGION_BITS];
  assign strobe = sys_wen_i | sys_ren_i;

  always_comb begin
    for (int i = 0; i < NUM_REGIONS; i++) begin
      reg_cs[i]    = (region == pitaya_pkg::REGION_BITS'(i));
      free_mask[i] = (i >= FIRST_FREE);
    end
  end

  assign cfg_cs = (region == pitaya_pkg::SYSCONF_REGION);
  assign unk_cs = ~(|reg_cs) & ~cfg_cs;  // nothing answers here

  // strobe fan-out
  assign reg_wen_o = reg_cs & {NUM_REGIONS{sys_wen_i}};
  assign reg_ren_o = reg_cs & {NUM_REGIONS{sys_ren_i}};
  assign cfg_wen_o = cfg_cs & sys_wen_i;
  assign cfg_ren_o = cfg_cs & sys_ren_i;

  // ----------------------------------------
  // local responders
  // ----------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      free_ack_q <= '0;
      unk_ack_q  <= 1'b0;
    end else begin
      free_ack_q <= reg_cs & free_mask & {NUM_REGIONS{strobe}};  // one cycle later
      unk_ack_q  <= unk_cs & strobe;
    end
  end

  // ----------------------------------------
  // response merge, per bit line
  // ----------------------------------------
  always_comb begin
    sys_rdata_o = cfg_rdata_i & {pitaya_pkg::BUS_W{cfg_cs}};
    for (int b = 0; b < pitaya_pkg::BUS_W; b++) begin
      for (int r = 0; r < NUM_REGIONS; r++) begin
        sys_rdata_o[b] = sys_rdata_o[b] | (reg_cs[r] & reg_rdata_i[r*pitaya_pkg::BUS_W+b]);
      end
    end
  end

  assign sys_ack_o = |(reg_cs & (reg_ack_i | free_ack_q)) | (cfg_cs & cfg_ack_i) | unk_ack_q;
  assign sys_err_o = |(reg_cs & reg_err_i) | unk_ack_q;  // table never errs

endmodule

//--- hw/sysconf_rom.sv
module sysconf_rom #(
  parameter int NUM_REGIONS = 8
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  input  logic [pitaya_pkg::REGION_LSB-1:0]    addr_i,   // offset in region
  input  logic                                 ren_i,
  input  logic                                 wen_i,    // acked, no effect
  output logic [pitaya_pkg::BUS_W-1:0]         rdata_o,
  output logic                                 ack_o
);

  pitaya_pkg::sysconf_word_t entry;

  // table lookup
  always_comb begin
    entry = '0;
    case (addr_i)
      20'hf0000: entry.raw = pitaya_pkg::SYSCONF_ID;
      20'hf0004: entry.raw = pitaya_pkg::BUS_W'(NUM_REGIONS);
      pitaya_pkg::IRQ_CFG_BASE: begin           // hk
        entry.irq_cfg.line_en = 4'b1000;        // line 0 only
        entry.irq_cfg.num0    = 4'd10;
      end
      pitaya_pkg::IRQ_CFG_BASE + 20'h4: begin   // region 1
        entry.irq_cfg.line_en = 4'b1000;
        entry.irq_cfg.num0    = 4'd4;
      end
      default: entry = '0;                      // unlisted reads zero
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o   <= ren_i | wen_i;
      rdata_o <= ren_i ? entry.raw : '0;
    end
  end

endmodule

//--- hw/hk_regs.sv
module hk_regs (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  input  logic [pitaya_pkg::REGION_LSB-1:0]    addr_i,
  input  logic [pitaya_pkg::BUS_W-1:0]         wdata_i,
  input  logic                                 wen_i,
  input  logic                                 ren_i,
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] adc_a_i,  // converted sample
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] adc_b_i,
  output logic [pitaya_pkg::BUS_W-1:0]         rdata_o,
  output logic                                 ack_o,
  output logic                                 err_o,
  output logic [7:0]                           led_o
);

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_o   <= '0;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o   <= wen_i | ren_i;
      err_o   <= 1'b0;
      rdata_o <= '0;
      case (addr_i)
        20'h00: begin
          if (wen_i) led_o <= wdata_i[7:0];
          if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(led_o);
        end
        20'h04: if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(adc_a_i);  // sign-extends
        20'h08: if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(adc_b_i);
        default: err_o <= wen_i | ren_i;  // unknown offset
      endcase
    end
  end

endmodule

//--- hw/dc_level_gen.sv
module dc_level_gen (
  input  logic                                   adc_clk,
  input  logic                                   rst_n_i,
  input  logic [pitaya_pkg::REGION_LSB-1:0]      addr_i,
  input  logic [pitaya_pkg::BUS_W-1:0]           wdata_i,
  input  logic                                   wen_i,
  input  logic                                   ren_i,
  output logic [pitaya_pkg::BUS_W-1:0]           rdata_o,
  output logic                                   ack_o,
  output logic                                   err_o,
  output logic signed [pitaya_pkg::SAMPLE_W-1:0] level_a_o,  // straight to dac sum
  output logic signed [pitaya_pkg::SAMPLE_W-1:0] level_b_o
);

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      level_a_o <= '0;
      level_b_o <= '0;
      ack_o     <= 1'b0;
      err_o     <= 1'b0;
      rdata_o   <= '0;
    end else begin
      ack_o   <= wen_i | ren_i;
      err_o   <= 1'b0;
      rdata_o <= '0;
      case (addr_i)
        20'h00: begin                                          // level a
          if (wen_i) level_a_o <= wdata_i[pitaya_pkg::SAMPLE_W-1:0];
          if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(level_a_o);
        end
        20'h04: begin                                          // level b
          if (wen_i) level_b_o <= wdata_i[pitaya_pkg::SAMPLE_W-1:0];
          if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(level_b_o);
        end
        default: err_o <= wen_i | ren_i;
      endcase
    end
  end

endmodule

//--- hw/prop_ctrl.sv
module prop_ctrl #(
  parameter int KP_SHIFT = 4
) (
  input  logic                                   adc_clk,
  input  logic                                   rst_n_i,
  input  logic [pitaya_pkg::REGION_LSB-1:0]      addr_i,
  input  logic [pitaya_pkg::BUS_W-1:0]           wdata_i,
  input  logic                                   wen_i,
  input  logic                                   ren_i,
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] adc_a_i,
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] adc_b_i,
  output logic [pitaya_pkg::BUS_W-1:0]           rdata_o,
  output logic                                   ack_o,
  output logic                                   err_o,
  output logic signed [pitaya_pkg::SAMPLE_W-1:0] ctrl_a_o,
  output logic signed [pitaya_pkg::SAMPLE_W-1:0] ctrl_b_o
);

  logic signed [pitaya_pkg::SAMPLE_W-1:0] sp_a, sp_b;      // setpoints
  logic signed [7:0]                      gain_a, gain_b;

  // gain * (sp - x) >>> shift, then clamp
  function automatic logic signed [pitaya_pkg::SAMPLE_W-1:0] p_term(
    input logic signed [pitaya_pkg::SAMPLE_W-1:0] sp,
    input logic signed [7:0]                      gain,
    input logic signed [pitaya_pkg::SAMPLE_W-1:0] x
  );
    logic signed [pitaya_pkg::SAMPLE_W:0]   err;   // 15 bit, no wrap
    logic signed [pitaya_pkg::SAMPLE_W+8:0] prod;
    err  = sp - x;
    prod = err * gain;
    return pitaya_pkg::sat_sample(prod >>> KP_SHIFT);
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sp_a     <= '0;
      sp_b     <= '0;
      gain_a   <= '0;
      gain_b   <= '0;
      ctrl_a_o <= '0;
      ctrl_b_o <= '0;
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      rdata_o  <= '0;
    end else begin
      ctrl_a_o <= p_term(sp_a, gain_a, adc_a_i);  // every cycle
      ctrl_b_o <= p_term(sp_b, gain_b, adc_b_i);
      ack_o    <= wen_i | ren_i;
      err_o    <= 1'b0;
      rdata_o  <= '0;
      case (addr_i)
        20'h00: begin
          if (wen_i) sp_a <= wdata_i[pitaya_pkg::SAMPLE_W-1:0];
          if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(sp_a);
        end
        20'h04: begin
          if (wen_i) sp_b <= wdata_i[pitaya_pkg::SAMPLE_W-1:0];
          if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(sp_b);
        end
        20'h08: begin
          if (wen_i) gain_a <= wdata_i[7:0];
          if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(gain_a);
        end
        20'h0c: begin
          if (wen_i) gain_b <= wdata_i[7:0];
          if (ren_i) rdata_o <= pitaya_pkg::BUS_W'(gain_b);
        end
        default: err_o <= wen_i | ren_i;
      endcase
    end
  end

endmodule

//--- hw/analog_frontend.sv
module analog_frontend (
  input  logic                                   adc_clk,
  input  logic                                   rst_n_i,
  input  logic [pitaya_pkg::SAMPLE_W-1:0]        adc_raw_a_i,  // unsigned neg-slope
  input  logic [pitaya_pkg::SAMPLE_W-1:0]        adc_raw_b_i,
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] level_a_i,
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] level_b_i,
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] ctrl_a_i,
  input  logic signed [pitaya_pkg::SAMPLE_W-1:0] ctrl_b_i,
  output logic signed [pitaya_pkg::SAMPLE_W-1:0] adc_a_o,      // two's complement
  output logic signed [pitaya_pkg::SAMPLE_W-1:0] adc_b_o,
  output logic [pitaya_pkg::SAMPLE_W-1:0]        dac_a_o,
  output logic [pitaya_pkg::SAMPLE_W-1:0]        dac_b_o
);

  // keep sign, invert the rest; same rule both ways
  function automatic logic [pitaya_pkg::SAMPLE_W-1:0] flip_code(
    input logic [pitaya_pkg::SAMPLE_W-1:0] v
  );
    return {v[pitaya_pkg::SAMPLE_W-1], ~v[pitaya_pkg::SAMPLE_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
      dac_a_o <= flip_code('0);  // code for zero, 0x1fff
      dac_b_o <= flip_code('0);
    end else begin
      adc_a_o <= flip_code(adc_raw_a_i);
      adc_b_o <= flip_code(adc_raw_b_i);
      dac_a_o <= flip_code(pitaya_pkg::sat_sample(level_a_i + ctrl_a_i));  // saturating sum
      dac_b_o <= flip_code(pitaya_pkg::sat_sample(level_b_i + ctrl_b_i));
    end
  end

endmodule

//--- hw/pitaya_core.sv
module pitaya_core #(
  parameter int NUM_REGIONS = 8,
  parameter int FIRST_FREE  = 3,
  parameter int KP_SHIFT    = 4
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  input  logic [pitaya_pkg::BUS_W-1:0]         sys_addr_i,
  input  logic [pitaya_pkg::BUS_W-1:0]         sys_wdata_i,
  input  logic                                 sys_wen_i,    // one cycle pulse
  input  logic                                 sys_ren_i,    // one cycle pulse
  output logic [pitaya_pkg::BUS_W-1:0]         sys_rdata_o,
  output logic                                 sys_ack_o,
  output logic                                 sys_err_o,
  input  logic [pitaya_pkg::SAMPLE_W-1:0]      adc_a_i,      // raw neg-slope code
  input  logic [pitaya_pkg::SAMPLE_W-1:0]      adc_b_i,
  output logic [pitaya_pkg::SAMPLE_W-1:0]      dac_a_o,      // dac code
  output logic [pitaya_pkg::SAMPLE_W-1:0]      dac_b_o,
  output logic [7:0]                           led_o
);

  localparam int N_FUNC = 3;  // hk, dc level, controller

  logic [NUM_REGIONS-1:0]                    reg_wen, reg_ren;
  logic [pitaya_pkg::BUS_W-1:0]              hk_rdata, dc_rdata, pc_rdata, cfg_rdata;
  logic                                      hk_ack, dc_ack, pc_ack, cfg_ack;
  logic                                      hk_err, dc_err, pc_err;
  logic                                      cfg_wen, cfg_ren;
  logic signed [pitaya_pkg::SAMPLE_W-1:0]    adc_a, adc_b;      // two's complement
  logic signed [pitaya_pkg::SAMPLE_W-1:0]    level_a, level_b;
  logic signed [pitaya_pkg::SAMPLE_W-1:0]    ctrl_a, ctrl_b;

  // ----------------------------------------
  // bus fabric
  // ----------------------------------------
  sys_bus_decoder #(
    .NUM_REGIONS (NUM_REGIONS),
    .FIRST_FREE  (FIRST_FREE)
  ) i_dec (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .reg_rdata_i ({{((NUM_REGIONS - N_FUNC) * pitaya_pkg::BUS_W){1'b0}},
                   pc_rdata, dc_rdata, hk_rdata}),  // free slots read zero
    .reg_ack_i   ({{(NUM_REGIONS - N_FUNC){1'b0}}, pc_ack, dc_ack, hk_ack}),
    .reg_err_i   ({{(NUM_REGIONS - N_FUNC){1'b0}}, pc_err, dc_err, hk_err}),
    .cfg_rdata_i (cfg_rdata),
    .cfg_ack_i   (cfg_ack),
    .reg_wen_o   (reg_wen),
    .reg_ren_o   (reg_ren),
    .cfg_wen_o   (cfg_wen),
    .cfg_ren_o   (cfg_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  sysconf_rom #(.NUM_REGIONS(NUM_REGIONS)) i_cfg (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .addr_i  (sys_addr_i[pitaya_pkg::REGION_LSB-1:0]),
    .ren_i   (cfg_ren),
    .wen_i   (cfg_wen),
    .rdata_o (cfg_rdata),
    .ack_o   (cfg_ack)
  );

  // ----------------------------------------
  // register regions 0..2
  // ----------------------------------------
  hk_regs i_hk (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .addr_i  (sys_addr_i[pitaya_pkg::REGION_LSB-1:0]),
    .wdata_i (sys_wdata_i),
    .wen_i   (reg_wen[0]),
    .ren_i   (reg_ren[0]),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .rdata_o (hk_rdata),
    .ack_o   (hk_ack),
    .err_o   (hk_err),
    .led_o   (led_o)
  );

  dc_level_gen i_dc (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .addr_i    (sys_addr_i[pitaya_pkg::REGION_LSB-1:0]),
    .wdata_i   (sys_wdata_i),
    .wen_i     (reg_wen[1]),
    .ren_i     (reg_ren[1]),
    .rdata_o   (dc_rdata),
    .ack_o     (dc_ack),
    .err_o     (dc_err),
    .level_a_o (level_a),
    .level_b_o (level_b)
  );

  prop_ctrl #(.KP_SHIFT(KP_SHIFT)) i_pc (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .addr_i   (sys_addr_i[pitaya_pkg::REGION_LSB-1:0]),
    .wdata_i  (sys_wdata_i),
    .wen_i    (reg_wen[2]),
    .ren_i    (reg_ren[2]),
    .adc_a_i  (adc_a),
    .adc_b_i  (adc_b),
    .rdata_o  (pc_rdata),
    .ack_o    (pc_ack),
    .err_o    (pc_err),
    .ctrl_a_o (ctrl_a),
    .ctrl_b_o (ctrl_b)
  );

  // ----------------------------------------
  // analog path
  // ----------------------------------------
  analog_frontend i_afe (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_raw_a_i (adc_a_i),
    .adc_raw_b_i (adc_b_i),
    .level_a_i   (level_a),
    .level_b_i   (level_b),
    .ctrl_a_i    (ctrl_a),
    .ctrl_b_i    (ctrl_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o)
  );

endmodule

//--- bench/tb_pitaya_core.sv
module tb_pitaya_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REGIONS = 8;
  localparam int FIRST_FREE  = 3;
  localparam int KP_SHIFT    = 4;
  localparam int SW          = pitaya_pkg::SAMPLE_W;
  localparam int BW          = pitaya_pkg::BUS_W;
  localparam logic [BW-1:0] CFG_BASE = 32'h3ff00000;  // top region

  logic          adc_clk = 1'b0;
  logic          rst_n_i;
  logic [BW-1:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic          sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  logic [SW-1:0] adc_a_i, adc_b_i, dac_a_o, dac_b_o;
  logic [7:0]    led_o;

  logic [BW-1:0] rd;                 // last read word
  logic          rerr;               // last err flag
  string         chk_name;           // handed to the compare process
  logic [SW-1:0] chk_exp_a, chk_exp_b;
  logic          chk_busy = 1'b0;
  event          dac_check_ev;

  pitaya_core #(
    .NUM_REGIONS (NUM_REGIONS),
    .FIRST_FREE  (FIRST_FREE),
    .KP_SHIFT    (KP_SHIFT)
  ) dut_i (.*);

  always #2 adc_clk = ~adc_clk;      // 4 ns period

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic int adc_conv(input logic [SW-1:0] raw);
    logic [SW-1:0] c;
    c = {raw[SW-1], ~raw[SW-2:0]};   // sign kept and rest inverted
    return int'($signed(c));
  endfunction

  function automatic logic [SW-1:0] dac_code(input int v);
    logic [SW-1:0] s;
    s = SW'(v);
    return {s[SW-1], ~s[SW-2:0]};
  endfunction

  function automatic int sat_model(input int v);
    if (v > 8191) return 8191;
    if (v < -8192) return -8192;
    return v;
  endfunction

  function automatic int ctrl_model(input int sp, input int gain, input int x);
    int e;
    int p;
    e = sp - x;                      // 15 bit range without wrap
    p = e * gain;
    return sat_model(p >>> KP_SHIFT);
  endfunction

  function automatic logic [BW-1:0] cfg_word(input logic en0, input logic [3:0] num0);
    pitaya_pkg::sysconf_word_t w;
    w = '0;
    w.irq_cfg.line_en[0] = en0;      // line 0 only
    w.irq_cfg.num0       = num0;
    return w.raw;
  endfunction

  function automatic logic [BW-1:0] sext(input logic [BW-1:0] v, input int bits);
    logic [BW-1:0] r;
    r = v << (BW - bits);
    return $signed(r) >>> (BW - bits);
  endfunction

  function automatic logic [BW-1:0] reg_addr(input int region, input int offset);
    return (BW'(region) << pitaya_pkg::REGION_LSB) | BW'(offset);
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic stop_failed();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [BW-1:0] exp,
                            input logic [BW-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_sample(input string name, input logic [SW-1:0] exp,
                              input logic [SW-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_failed();
    end
  endtask

  // dac compare process running beside the stimulus
  always begin
    @(dac_check_ev);
    check_sample({chk_name, "_a"}, chk_exp_a, dac_a_o);
    check_sample({chk_name, "_b"}, chk_exp_b, dac_b_o);
    chk_busy = 1'b0;
  end

  task automatic request_dac_check(input string name, input logic [SW-1:0] exp_a,
                                   input logic [SW-1:0] exp_b);
    int waited;
    chk_name  = name;
    chk_exp_a = exp_a;
    chk_exp_b = exp_b;
    chk_busy  = 1'b1;
    -> dac_check_ev;
    waited = 0;
    while (chk_busy && waited < 10) begin
      @(negedge adc_clk);
      waited++;
    end
    if (chk_busy) begin
      $display("the DAC compare process did not answer for %s", name);
      stop_failed();
    end
  endtask

  // ----------------------------------------
  // bus access
  // ----------------------------------------
  task automatic bus_access(input logic wr, input logic [BW-1:0] addr,
                            input logic [BW-1:0] wdata);
    int waited;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    @(negedge adc_clk);
    sys_wen_i = 1'b0;                // single cycle strobe
    sys_ren_i = 1'b0;
    waited = 0;
    while (!sys_ack_o && waited < 10) begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack_o) begin
      $display("no acknowledge came for address %h", addr);
      stop_failed();
    end else begin
      rd   = sys_rdata_o;            // valid with ack
      rerr = sys_err_o;
    end
  endtask

  task automatic bus_write(input logic [BW-1:0] addr, input logic [BW-1:0] wdata);
    bus_access(1'b1, addr, wdata);
  endtask

  task automatic bus_read(input logic [BW-1:0] addr);
    bus_access(1'b0, addr, '0);
  endtask

  task automatic write_readback(input string name, input logic [BW-1:0] addr,
                                input logic [BW-1:0] wdata, input logic [BW-1:0] exp);
    bus_write(addr, wdata);
    check_flag({name, "_werr"}, 1'b0, rerr);
    bus_read(addr);
    check_flag({name, "_rerr"}, 1'b0, rerr);
    check_word(name, exp, rd);
  endtask

  // all six registers and both adc words, then compare after settle
  task automatic mix_case(input string name,
                          input logic signed [SW-1:0] lvl_a, input logic signed [SW-1:0] lvl_b,
                          input logic signed [SW-1:0] sp_a, input logic signed [SW-1:0] sp_b,
                          input logic signed [7:0] g_a, input logic signed [7:0] g_b,
                          input logic [SW-1:0] raw_a, input logic [SW-1:0] raw_b);
    int sum_a;
    int sum_b;
    @(negedge adc_clk);
    adc_a_i = raw_a;
    adc_b_i = raw_b;
    bus_write(reg_addr(1, 'h0), BW'(lvl_a));
    bus_write(reg_addr(1, 'h4), BW'(lvl_b));
    bus_write(reg_addr(2, 'h0), BW'(sp_a));
    bus_write(reg_addr(2, 'h4), BW'(sp_b));
    bus_write(reg_addr(2, 'h8), BW'(g_a));
    bus_write(reg_addr(2, 'hc), BW'(g_b));
    repeat (4) @(negedge adc_clk);   // 3 cycle path plus margin
    sum_a = int'(lvl_a) + ctrl_model(int'(sp_a), int'(g_a), adc_conv(raw_a));
    sum_b = int'(lvl_b) + ctrl_model(int'(sp_b), int'(g_b), adc_conv(raw_b));
    request_dac_check(name, dac_code(sat_model(sum_a)), dac_code(sat_model(sum_b)));
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic [BW-1:0]            w;
    logic [SW-1:0]            raw_a, raw_b;
    logic signed [SW-1:0]     lv_a, lv_b;
    pitaya_pkg::sysconf_word_t cw;
    void'($urandom(64));
    rst_n_i     = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_a_i     = '0;
    adc_b_i     = '0;
    repeat (2) @(negedge adc_clk);
    rst_n_i = 1'b1;
    check_flag("reset_ack", 1'b0, sys_ack_o);
    check_flag("reset_err", 1'b0, sys_err_o);
    check_led("reset_led", 8'h00, led_o);
    repeat (3) @(negedge adc_clk);
    request_dac_check("reset_dac", dac_code(0), dac_code(0));

    // configuration table
    bus_read(CFG_BASE | 32'hf0000);
    check_word("cfg_id", pitaya_pkg::SYSCONF_ID, rd);
    check_flag("cfg_id_err", 1'b0, rerr);
    bus_read(CFG_BASE | 32'hf0004);
    check_word("cfg_regions", BW'(NUM_REGIONS), rd);
    bus_read(CFG_BASE | 32'hf0100);
    check_word("cfg_irq_hk", cfg_word(1'b1, 4'd10), rd);
    cw.raw = rd;                     // decode through the union
    check_flag("cfg_irq_hk_en", 1'b1, cw.irq_cfg.line_en[0]);
    check_word("cfg_irq_hk_num", BW'(10), BW'(cw.irq_cfg.num0));
    bus_read(CFG_BASE | 32'hf0104);
    check_word("cfg_irq_dc", cfg_word(1'b1, 4'd4), rd);
    cw.raw = rd;
    check_flag("cfg_irq_dc_en", 1'b1, cw.irq_cfg.line_en[0]);
    check_word("cfg_irq_dc_num", BW'(4), BW'(cw.irq_cfg.num0));
    bus_read(CFG_BASE | 32'hf0108);
    check_word("cfg_unlisted_a", '0, rd);
    bus_read(CFG_BASE | 32'h00010);
    check_word("cfg_unlisted_b", '0, rd);
    check_flag("cfg_unlisted_err", 1'b0, rerr);

    // register readback
    write_readback("led", reg_addr(0, 'h0), 32'h5a5a00a5, 32'h000000a5);
    check_led("led_o", 8'ha5, led_o);
    w = $urandom;
    write_readback("level_a", reg_addr(1, 'h0), w, sext(w, SW));
    w = $urandom | 32'h2000;         // negative level
    write_readback("level_b", reg_addr(1, 'h4), w, sext(w, SW));
    w = $urandom;
    write_readback("setpoint_a", reg_addr(2, 'h0), w, sext(w, SW));
    w = $urandom;
    write_readback("setpoint_b", reg_addr(2, 'h4), w, sext(w, SW));
    w = $urandom | 32'h80;
    write_readback("gain_a", reg_addr(2, 'h8), w, sext(w, 8));
    w = $urandom;
    write_readback("gain_b", reg_addr(2, 'hc), w, sext(w, 8));

    // free, unknown region and bad offset
    bus_read(reg_addr(5, 'h10));
    check_word("free_rdata", '0, rd);
    check_flag("free_err", 1'b0, rerr);
    bus_write(reg_addr(5, 'h0), 32'h12345678);
    check_flag("free_werr", 1'b0, rerr);
    bus_read(reg_addr('h200, 'h0));
    check_flag("unknown_region_err", 1'b1, rerr);
    bus_read(reg_addr(0, 'h40));
    check_flag("hk_bad_offset_err", 1'b1, rerr);
    check_word("hk_bad_offset_rdata", '0, rd);

    // adc readback
    for (int i = 0; i < 20; i++) begin
      raw_a = SW'($urandom);
      raw_b = SW'($urandom);
      @(negedge adc_clk);
      adc_a_i = raw_a;
      adc_b_i = raw_b;
      repeat (2) @(negedge adc_clk);
      bus_read(reg_addr(0, 'h4));
      check_word("adc_a_readback", BW'(adc_conv(raw_a)), rd);
      bus_read(reg_addr(0, 'h8));
      check_word("adc_b_readback", BW'(adc_conv(raw_b)), rd);
    end

    // level only with the controller off
    bus_write(reg_addr(2, 'h8), '0);
    bus_write(reg_addr(2, 'hc), '0);
    for (int i = 0; i < 10; i++) begin
      lv_a = SW'($urandom);
      lv_b = SW'($urandom);
      bus_write(reg_addr(1, 'h0), BW'(lv_a));
      bus_write(reg_addr(1, 'h4), BW'(lv_b));
      repeat (4) @(negedge adc_clk);
      request_dac_check("dac_level", dac_code(int'(lv_a)), dac_code(int'(lv_b)));
    end

    // full data path with random and full scale values
    for (int i = 0; i < 20; i++) begin
      mix_case("dac_mix", SW'($urandom), SW'($urandom), SW'($urandom), SW'($urandom),
               8'($urandom), 8'($urandom), SW'($urandom), SW'($urandom));
    end
    mix_case("dac_sat_hi", 14'sd8191, -14'sd8192, 14'sd8191, -14'sd8192,
             8'sd127, 8'sd127, 14'h3fff, 14'h0000);
    mix_case("dac_ctrl_sat", -14'sd8192, 14'sd8191, -14'sd8192, 14'sd8191,
             -8'sd128, -8'sd128, 14'h0000, 14'h3fff);
    mix_case("dac_sum_sat", -14'sd8192, 14'sd8100, 14'sd0, 14'sd0,
             8'sd1, 8'sd1, 14'h0000, 14'h2fff);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- pitaya_core.f
hw/pitaya_pkg.sv
hw/sys_bus_decoder.sv
hw/sysconf_rom.sv
hw/hk_regs.sv
hw/dc_level_gen.sv
hw/prop_ctrl.sv
hw/analog_frontend.sv
hw/pitaya_core.sv
bench/tb_pitaya_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pitaya_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pitaya_core \
  -f pitaya_core.f -o tb_pitaya_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_pitaya_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
